//--- rtl/pw_reg_defs.svh
`ifndef PW_REG_DEFS_SVH
`define PW_REG_DEFS_SVH

////////////////////////////////////////////////
// bus and field widths
////////////////////////////////////////////////
`define PW_ADDR_W            8
`define PW_BYTECNT_W         7
`define PW_DATA_W            8
`define PW_PAGE_MAIN         2'b00   // top two address bits
`define PW_FE_SELECT_W       2
`define PW_FE_USB            2'd0
`define PW_NUM_TRIG          8
`define PW_TRIG_FIELD_W      24      // per pulse, delay and width
`define PW_NUM_TRIG_W        4
`define PW_CAPTURE_LEN_W     24
`define PW_FIFO_W            18
`define PW_FIFO_DATA_W       16
`define PW_FIFO_STAT_W       6

// stream-empty marker word
`define PW_FIFO_CMD_STRM     2'b10
`define PW_FIFO_STRM_EMPTY   16'h0002

`define PW_QUICK_START_DEFAULT 1'b0

////////////////////////////////////////////////
// main page register offsets
////////////////////////////////////////////////
`define REG_SNIFF_FIFO_STAT     6'h03
`define REG_SNIFF_FIFO_RD       6'h04
`define REG_FE_SELECT           6'h06
`define REG_ARM                 6'h08
`define REG_TRIGGER_ENABLE      6'h0c
`define REG_TRIGGER_DELAY       6'h0d
`define REG_TRIGGER_WIDTH       6'h0e
`define REG_NUM_TRIGGERS        6'h0f
`define REG_CAPTURE_LEN         6'h10
`define REG_COUNT_WRITES        6'h11
`define REG_COUNTER_QUICK_START 6'h15
`define REG_TIMESTAMPS_DISABLE  6'h1b
`define REG_CAPTURE_WHILE_TRIG  6'h1d
`define REG_MAX_TIMESTAMP       6'h1e

`endif

//--- rtl/pw_reg_pkg.sv
`include "pw_reg_defs.svh"

package pw_reg_pkg;

   // byte-wise register bus, as seen from the USB side
   typedef struct packed {
      logic [`PW_ADDR_W-1:0]    addr;
      logic [`PW_BYTECNT_W-1:0] bytecnt;
      logic [`PW_DATA_W-1:0]    wdata;
      logic                     read;
      logic                     write;
      logic                     addrvalid;
   } reg_bus_t;

   typedef struct packed {
      logic                                      enable;
      logic [`PW_NUM_TRIG_W-1:0]                 num_triggers;
      logic [`PW_NUM_TRIG*`PW_TRIG_FIELD_W-1:0]  delay;    // pulse 0 in the low bits
      logic [`PW_NUM_TRIG*`PW_TRIG_FIELD_W-1:0]  width;
   } trig_cfg_t;

   typedef struct packed {
      logic [`PW_CAPTURE_LEN_W-1:0] capture_len;
      logic                         count_writes;
      logic                         quick_start;
      logic                         timestamps_disable;
      logic                         capture_while_trig;
      logic [15:0]                  max_timestamp;
   } capture_cfg_t;

   // one capture FIFO entry
   typedef struct packed {
      logic [`PW_FIFO_W-`PW_FIFO_DATA_W-1:0] cmd;
      logic [`PW_FIFO_DATA_W-1:0]            data;
   } fifo_word_t;

endpackage

//--- rtl/cdc_pulse.sv
`timescale 1ns/1ps

module cdc_pulse (
   input  logic src_clk,
   input  logic dst_clk,
   input  logic fpga_reset,
   input  logic src_pulse,
   output logic dst_pulse
);

   logic       src_toggle;
   logic [2:0] dst_sync;   // two sync stages plus one for edge detect

   always_ff @(posedge src_clk) begin
      if (fpga_reset)
         src_toggle <= 1'b0;
      else if (src_pulse)
         src_toggle <= ~src_toggle;
   end

   always_ff @(posedge dst_clk) begin
      if (fpga_reset)
         dst_sync <= '0;
      else
         dst_sync <= {dst_sync[1:0], src_toggle};
   end

   // any change of the toggle is one event
   assign dst_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

//--- rtl/arm_control.sv
`timescale 1ns/1ps

module arm_control (
   input  logic       cwusb_clk,
   input  logic       fpga_reset,
   input  logic       arm_wr,          // write strobe to the arm register
   input  logic [1:0] wr_bits,         // bit 0 arm, bit 1 capture now
   input  logic       flushing,
   input  logic       capture_done,    // already in cwusb_clk domain
   output logic       arm,
   output logic       reg_arm,
   output logic       arm_pulse,
   output logic       capture_now
);

   logic reg_arm_r;
   logic capture_now_q;
   logic capture_now_r;

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         reg_arm       <= 1'b0;
         reg_arm_r     <= 1'b0;
         capture_now_q <= 1'b0;
         capture_now_r <= 1'b0;
      end else begin
         reg_arm_r     <= reg_arm;
         capture_now_r <= capture_now_q;
         capture_now_q <= arm_wr && wr_bits[1];
         if (arm_wr && wr_bits[0])
            reg_arm <= 1'b1;
         else if (capture_done)
            reg_arm <= 1'b0;   // front end has started capturing
      end
   end

   // rising edges only
   assign arm_pulse   = reg_arm && !reg_arm_r;
   assign capture_now = capture_now_q && !capture_now_r;
   assign arm         = reg_arm_r && !flushing;

endmodule

//--- rtl/fifo_read_port.sv
`timescale 1ns/1ps
`include "pw_reg_defs.svh"

module fifo_read_port (
   input  logic                          cwusb_clk,
   input  logic                          fpga_reset,
   input  pw_reg_pkg::reg_bus_t          bus,
   input  logic                          selected,
   input  pw_reg_pkg::fifo_word_t        fifo_data,
   input  logic [`PW_FIFO_STAT_W-1:0]    fifo_status,
   input  logic                          fifo_empty,
   output logic                          fifo_read,
   output logic                          fifo_sel,
   output logic [`PW_DATA_W-1:0]         rd_byte
);

   logic                    read_r;
   logic                    empty_r;
   logic                    first_rd;
   pw_reg_pkg::fifo_word_t  word_r;

   ////////////////////////////////////////////////
   // pop on the first cycle of a byte-0 read
   ////////////////////////////////////////////////
   assign fifo_sel = selected && (bus.addr[5:0] == `REG_SNIFF_FIFO_RD);
   assign first_rd = fifo_sel && bus.read && !read_r && (bus.bytecnt[1:0] == 2'd0);
   assign fifo_read = first_rd && !empty_r;

   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         read_r  <= 1'b0;
         empty_r <= 1'b1;   // no pop straight out of reset
      end else begin
         read_r  <= bus.read;
         empty_r <= fifo_empty;
      end
   end

   // each byte-0 access decides on its own
   always_ff @(posedge cwusb_clk) begin
      if (first_rd) begin
         if (empty_r)
            word_r <= {`PW_FIFO_CMD_STRM, `PW_FIFO_STRM_EMPTY};   // stream-empty marker
         else
            word_r <= fifo_data;
      end
   end

   ////////////////////////////////////////////////
   // byte select within the 4-byte window
   ////////////////////////////////////////////////
   always_comb begin
      rd_byte = '0;
      if (fifo_sel && bus.read) begin
         case (bus.bytecnt[1:0])
            2'd1:    rd_byte = word_r.data[7:0];
            2'd2:    rd_byte = word_r.data[15:8];
            2'd3:    rd_byte = {fifo_status, word_r.cmd};
            default: rd_byte = '0;   // byte 0 is the pop cycle
         endcase
      end
   end

   // registered empty flag must never let a pop through on an empty FIFO
   no_pop_when_empty_a : assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      !(fifo_read && fifo_empty));

endmodule

//--- rtl/reg_config_bank.sv
`timescale 1ns/1ps
`include "pw_reg_defs.svh"

module reg_config_bank (
   input  logic                          cwusb_clk,
   input  logic                          fpga_reset,
   input  pw_reg_pkg::reg_bus_t          bus,
   input  logic                          selected,
   input  logic [`PW_FIFO_STAT_W-1:0]    fifo_status,
   input  logic                          arm_state,
   output logic [`PW_FE_SELECT_W-1:0]    fe_select,
   output pw_reg_pkg::trig_cfg_t         trig_cfg,
   output pw_reg_pkg::capture_cfg_t      capture_cfg,
   output logic [`PW_DATA_W-1:0]         rd_byte
);

   localparam int TRIG_BYTES   = `PW_NUM_TRIG * `PW_TRIG_FIELD_W / 8;
   localparam int CAPLEN_BYTES = `PW_CAPTURE_LEN_W / 8;

   logic [5:0] addr;
   logic       wr_en;

   assign addr  = bus.addr[5:0];
   assign wr_en = selected && bus.write;

   ////////////////////////////////////////////////
   // write side
   ////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         fe_select                      <= `PW_FE_USB;
         trig_cfg                       <= '0;
         trig_cfg.num_triggers          <= 1;
         capture_cfg                    <= '0;
         capture_cfg.quick_start        <= `PW_QUICK_START_DEFAULT;
         capture_cfg.max_timestamp      <= '1;
      end else if (wr_en) begin
         case (addr)
            `REG_FE_SELECT:           fe_select <= bus.wdata[`PW_FE_SELECT_W-1:0];
            `REG_TRIGGER_ENABLE:      trig_cfg.enable <= bus.wdata[0];
            `REG_TRIGGER_DELAY:       trig_cfg.delay[bus.bytecnt*8 +: `PW_DATA_W] <= bus.wdata;
            `REG_TRIGGER_WIDTH:       trig_cfg.width[bus.bytecnt*8 +: `PW_DATA_W] <= bus.wdata;
            `REG_NUM_TRIGGERS:        trig_cfg.num_triggers <= bus.wdata[`PW_NUM_TRIG_W-1:0];
            `REG_CAPTURE_LEN: begin
               capture_cfg.capture_len[bus.bytecnt*8 +: `PW_DATA_W] <= bus.wdata;
            end
            `REG_COUNT_WRITES:        capture_cfg.count_writes <= bus.wdata[0];
            `REG_COUNTER_QUICK_START: capture_cfg.quick_start <= bus.wdata[0];
            `REG_TIMESTAMPS_DISABLE:  capture_cfg.timestamps_disable <= bus.wdata[0];
            `REG_CAPTURE_WHILE_TRIG:  capture_cfg.capture_while_trig <= bus.wdata[0];
            `REG_MAX_TIMESTAMP: begin
               capture_cfg.max_timestamp[bus.bytecnt[0]*8 +: `PW_DATA_W] <= bus.wdata;
            end
            default: ;   // arm and fifo handled elsewhere
         endcase
      end
   end

   ////////////////////////////////////////////////
   // read mux, registered in the top
   ////////////////////////////////////////////////
   always_comb begin
      rd_byte = '0;
      if (selected && bus.read) begin
         case (addr)
            `REG_SNIFF_FIFO_STAT:     rd_byte = `PW_DATA_W'(fifo_status);
            `REG_FE_SELECT:           rd_byte = `PW_DATA_W'(fe_select);
            `REG_ARM:                 rd_byte = `PW_DATA_W'(arm_state);
            `REG_TRIGGER_ENABLE:      rd_byte = `PW_DATA_W'(trig_cfg.enable);
            `REG_TRIGGER_DELAY:       rd_byte = trig_cfg.delay[bus.bytecnt*8 +: `PW_DATA_W];
            `REG_TRIGGER_WIDTH:       rd_byte = trig_cfg.width[bus.bytecnt*8 +: `PW_DATA_W];
            `REG_NUM_TRIGGERS:        rd_byte = `PW_DATA_W'(trig_cfg.num_triggers);
            `REG_CAPTURE_LEN: begin
               rd_byte = capture_cfg.capture_len[bus.bytecnt*8 +: `PW_DATA_W];
            end
            `REG_COUNT_WRITES:        rd_byte = `PW_DATA_W'(capture_cfg.count_writes);
            `REG_COUNTER_QUICK_START: rd_byte = `PW_DATA_W'(capture_cfg.quick_start);
            `REG_TIMESTAMPS_DISABLE:  rd_byte = `PW_DATA_W'(capture_cfg.timestamps_disable);
            `REG_CAPTURE_WHILE_TRIG:  rd_byte = `PW_DATA_W'(capture_cfg.capture_while_trig);
            `REG_MAX_TIMESTAMP: begin
               rd_byte = capture_cfg.max_timestamp[bus.bytecnt[0]*8 +: `PW_DATA_W];
            end
            default:                  rd_byte = '0;
         endcase
      end
   end

   // host must keep the byte count inside the wide fields
   lane_in_range_a : assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      wr_en && (addr == `REG_TRIGGER_DELAY || addr == `REG_TRIGGER_WIDTH)
         |-> (bus.bytecnt < TRIG_BYTES));
   caplen_in_range_a : assert property (@(posedge cwusb_clk) disable iff (fpga_reset)
      wr_en && (addr == `REG_CAPTURE_LEN) |-> (bus.bytecnt < CAPLEN_BYTES));

endmodule

//--- rtl/reg_main.sv
`timescale 1ns/1ps
`include "pw_reg_defs.svh"

module reg_main (
   input  logic                          cwusb_clk,
   input  logic                          fpga_reset,
   input  logic                          fe_clk,
   input  logic [`PW_ADDR_W-1:0]         reg_address,
   input  logic [`PW_BYTECNT_W-1:0]      reg_bytecnt,
   input  logic [`PW_DATA_W-1:0]         write_data,
   input  logic                          reg_read,
   input  logic                          reg_write,
   input  logic                          reg_addrvalid,
   output logic [`PW_DATA_W-1:0]         read_data,
   output logic                          selected,
   input  pw_reg_pkg::fifo_word_t        fifo_data,
   input  logic [`PW_FIFO_STAT_W-1:0]    fifo_status,
   input  logic                          fifo_empty,
   output logic                          fifo_read,
   input  logic                          flushing,
   input  logic                          capture_enable_pulse,
   output logic                          arm,
   output logic                          reg_arm,
   output logic                          arm_pulse,
   output logic                          capture_now,
   output logic [`PW_FE_SELECT_W-1:0]    fe_select,
   output pw_reg_pkg::trig_cfg_t         trig_cfg,
   output pw_reg_pkg::capture_cfg_t      capture_cfg
);

   pw_reg_pkg::reg_bus_t    bus;
   logic [`PW_DATA_W-1:0]   bank_byte;
   logic [`PW_DATA_W-1:0]   fifo_byte;
   logic                    fifo_sel;
   logic                    arm_wr;
   logic                    capture_done;

   assign bus = '{addr: reg_address, bytecnt: reg_bytecnt, wdata: write_data,
                  read: reg_read, write: reg_write, addrvalid: reg_addrvalid};

   // page check lives here only
   assign selected = bus.addrvalid && (bus.addr[`PW_ADDR_W-1 -: 2] == `PW_PAGE_MAIN);
   assign arm_wr   = selected && bus.write && (bus.addr[5:0] == `REG_ARM);

   reg_config_bank u_bank (
      .cwusb_clk   (cwusb_clk),
      .fpga_reset  (fpga_reset),
      .bus         (bus),
      .selected    (selected),
      .fifo_status (fifo_status),
      .arm_state   (reg_arm),
      .fe_select   (fe_select),
      .trig_cfg    (trig_cfg),
      .capture_cfg (capture_cfg),
      .rd_byte     (bank_byte)
   );

   cdc_pulse u_capture_enable_cdc (
      .src_clk    (fe_clk),
      .dst_clk    (cwusb_clk),
      .fpga_reset (fpga_reset),
      .src_pulse  (capture_enable_pulse),
      .dst_pulse  (capture_done)
   );

   arm_control u_arm (
      .cwusb_clk    (cwusb_clk),
      .fpga_reset   (fpga_reset),
      .arm_wr       (arm_wr),
      .wr_bits      (write_data[1:0]),
      .flushing     (flushing),
      .capture_done (capture_done),
      .arm          (arm),
      .reg_arm      (reg_arm),
      .arm_pulse    (arm_pulse),
      .capture_now  (capture_now)
   );

   fifo_read_port u_fifo_port (
      .cwusb_clk   (cwusb_clk),
      .fpga_reset  (fpga_reset),
      .bus         (bus),
      .selected    (selected),
      .fifo_data   (fifo_data),
      .fifo_status (fifo_status),
      .fifo_empty  (fifo_empty),
      .fifo_read   (fifo_read),
      .fifo_sel    (fifo_sel),
      .rd_byte     (fifo_byte)
   );

   // one register stage on the read path
   always_ff @(posedge cwusb_clk) begin
      read_data <= fifo_sel ? fifo_byte : bank_byte;
   end

endmodule

//--- dv/reg_main_checker.sv
`timescale 1ns/1ps
`include "pw_reg_defs.svh"

module reg_main_checker (
   input  logic                     cwusb_clk,
   input  logic                     fpga_reset,
   input  logic                     chk_en,
   input  logic [2:0]               chk_obs,
   input  logic [31:0]              chk_exp,
   input  logic [8*16-1:0]          chk_name,
   input  logic [`PW_DATA_W-1:0]    read_data,
   input  logic                     selected,
   input  logic [`PW_FE_SELECT_W-1:0] fe_select,
   input  logic                     reg_arm,
   input  logic                     arm,
   input  logic                     arm_pulse,
   input  logic                     capture_now,
   input  logic                     fifo_read,
   input  logic                     fifo_empty,
   input  pw_reg_pkg::trig_cfg_t    trig_cfg,
   input  pw_reg_pkg::capture_cfg_t capture_cfg,
   output int                       value_errors,
   output int                       protocol_errors
);

   // observed value codes, same numbering as in the testbench table
   localparam logic [2:0] OBS_RDATA = 3'd1, OBS_CTRL = 3'd2, OBS_DELAY = 3'd3,
                          OBS_CAPLEN = 3'd4, OBS_POPS = 3'd5, OBS_FE_SEL = 3'd6,
                          OBS_SEL = 3'd7;

   int          pop_count;
   logic        arm_pulse_q;
   logic        capture_now_q;
   logic        selected_q;   // selected as seen on the last edge
   logic [31:0] actual;

   task automatic note_protocol_error(input string what);
      protocol_errors = protocol_errors + 1;
      $display("Error at %0t ns: %0s", $time, what);
   endtask

   initial begin
      value_errors    = 0;
      protocol_errors = 0;
   end

   always_comb begin
      case (chk_obs)
         OBS_RDATA:  actual = 32'(read_data);
         OBS_CTRL:   actual = {27'd0, reg_arm, arm, arm_pulse, capture_now, fifo_read};
         OBS_DELAY:  actual = trig_cfg.delay[31:0];   // pulse 0 and low byte of pulse 1
         OBS_CAPLEN: actual = 32'(capture_cfg.capture_len);
         OBS_POPS:   actual = 32'(pop_count);
         OBS_FE_SEL: actual = 32'(fe_select);
         OBS_SEL:    actual = {23'd0, selected_q, read_data};
         default:    actual = '0;
      endcase
   end

   // compare mid-cycle, after the edge that produced the value
   always @(negedge cwusb_clk) begin
      if (chk_en && (actual !== chk_exp)) begin
         value_errors = value_errors + 1;
         $display("** Error %0s: expected 0x%h, actual 0x%h", chk_name, chk_exp, actual);
      end
   end

   ////////////////////////////////////////////////
   // continuous port monitors
   ////////////////////////////////////////////////
   always @(posedge cwusb_clk) begin
      if (fpga_reset) begin
         pop_count     <= 0;
         arm_pulse_q   <= 1'b0;
         capture_now_q <= 1'b0;
         selected_q    <= 1'b0;
      end else begin
         if (fifo_read)
            pop_count <= pop_count + 1;
         arm_pulse_q   <= arm_pulse;
         capture_now_q <= capture_now;
         selected_q    <= selected;
         if (arm_pulse && arm_pulse_q)
            note_protocol_error("arm_pulse stayed high for two cycles");
         if (capture_now && capture_now_q)
            note_protocol_error("capture_now stayed high for two cycles");
         if (fifo_read && fifo_empty)
            note_protocol_error("fifo_read asserted while the FIFO was empty");
      end
   end

endmodule

//--- dv/reg_main_tb.sv
`timescale 1ns/1ps
`include "pw_reg_defs.svh"

module reg_main_tb;

   localparam logic [2:0] OP_WRITE = 3'd0, OP_READ = 3'd1, OP_PUSH = 3'd2,
                          OP_FE_PULSE = 3'd3, OP_FLUSH = 3'd4, OP_IDLE = 3'd5;
   // observed value codes, same numbering as in the checker
   localparam logic [2:0] OBS_NONE = 3'd0, OBS_RDATA = 3'd1, OBS_CTRL = 3'd2,
                          OBS_DELAY = 3'd3, OBS_CAPLEN = 3'd4, OBS_POPS = 3'd5,
                          OBS_FE_SEL = 3'd6, OBS_SEL = 3'd7;
   localparam logic [5:0] FIFO_STAT = 6'h2d;

   typedef struct packed {
      logic [8*16-1:0] name;
      logic [2:0]      op;
      logic [2:0]      obs;
      logic [7:0]      addr;
      logic [6:0]      bytecnt;
      logic [17:0]     data;
      logic [31:0]     exp;
   } entry_t;

   logic                        cwusb_clk, fe_clk, fpga_reset;
   logic [`PW_ADDR_W-1:0]       reg_address;
   logic [`PW_BYTECNT_W-1:0]    reg_bytecnt;
   logic [`PW_DATA_W-1:0]       write_data;
   logic [`PW_DATA_W-1:0]       read_data;
   logic                        reg_read, reg_write, reg_addrvalid, selected;
   pw_reg_pkg::fifo_word_t      fifo_data;
   logic [`PW_FIFO_STAT_W-1:0]  fifo_status;
   logic                        fifo_empty, fifo_read, flushing, capture_enable_pulse;
   logic                        arm, reg_arm, arm_pulse, capture_now;
   logic [`PW_FE_SELECT_W-1:0]  fe_select;
   pw_reg_pkg::trig_cfg_t       trig_cfg;
   pw_reg_pkg::capture_cfg_t    capture_cfg;

   logic                        chk_en;
   logic [2:0]                  chk_obs;
   logic [31:0]                 chk_exp;
   logic [8*16-1:0]             chk_name;
   int                          value_errors, protocol_errors, timeouts;

   entry_t                      tbl [0:39];
   int                          n_entries = 0;
   int                          seed = 70299;

   // capture FIFO model, first word falls through
   pw_reg_pkg::fifo_word_t      fifo_mem [0:15];
   logic [4:0]                  wr_ptr, rd_ptr;

   assign fifo_empty = (wr_ptr == rd_ptr);
   assign fifo_data  = fifo_mem[rd_ptr[3:0]];

   always @(posedge cwusb_clk) begin
      if (fpga_reset)
         rd_ptr <= '0;
      else if (fifo_read)
         rd_ptr <= rd_ptr + 1'b1;
   end

   reg_main reg_main_inst (.*);
   reg_main_checker port_checker (.*);

   initial begin
      cwusb_clk = 1'b0;
      forever #50 cwusb_clk = ~cwusb_clk;
   end

   initial begin
      fe_clk = 1'b0;
      forever #35 fe_clk = ~fe_clk;   // never lines up with a cwusb_clk edge
   end

   task automatic add_entry(input logic [8*16-1:0] name, input logic [2:0] op,
                            input logic [2:0] obs, input logic [7:0] addr,
                            input logic [6:0] bc, input logic [17:0] data,
                            input logic [31:0] exp);
      tbl[n_entries] = '{name, op, obs, addr, bc, data, exp};
      n_entries++;
   endtask

   ////////////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////////////
   task automatic build_table();
      logic [17:0] word;
      logic [15:0] empty_code;
      empty_code = `PW_FIFO_STRM_EMPTY;
      word = 18'($random(seed));
      add_entry("rst fe_select", OP_READ, OBS_RDATA, `REG_FE_SELECT, 0, 0, `PW_FE_USB);
      add_entry("rst fe_sel port", OP_IDLE, OBS_FE_SEL, 0, 0, 0, `PW_FE_USB);
      add_entry("rst num_trig", OP_READ, OBS_RDATA, `REG_NUM_TRIGGERS, 0, 0, 1);
      add_entry("rst max_ts b0", OP_READ, OBS_RDATA, `REG_MAX_TIMESTAMP, 0, 0, 8'hff);
      add_entry("rst max_ts b1", OP_READ, OBS_RDATA, `REG_MAX_TIMESTAMP, 1, 0, 8'hff);
      add_entry("rst cap_len b1", OP_READ, OBS_RDATA, `REG_CAPTURE_LEN, 1, 0, 0);
      add_entry("rst quick_start", OP_READ, OBS_RDATA, `REG_COUNTER_QUICK_START, 0, 0, 0);
      add_entry("wr delay b0", OP_WRITE, OBS_DELAY, `REG_TRIGGER_DELAY, 0, 8'h5a, 32'h5a);
      add_entry("wr delay b1", OP_WRITE, OBS_DELAY, `REG_TRIGGER_DELAY, 1, 8'hc3, 32'hc35a);
      add_entry("rd delay b1", OP_READ, OBS_RDATA, `REG_TRIGGER_DELAY, 1, 0, 8'hc3);
      add_entry("rd delay b0", OP_READ, OBS_RDATA, `REG_TRIGGER_DELAY, 0, 0, 8'h5a);
      add_entry("wr cap_len b2", OP_WRITE, OBS_CAPLEN, `REG_CAPTURE_LEN, 2, 8'h9e, 32'h9e0000);
      add_entry("rd cap_len b2", OP_READ, OBS_RDATA, `REG_CAPTURE_LEN, 2, 0, 8'h9e);
      add_entry("rd cap_len b0", OP_READ, OBS_RDATA, `REG_CAPTURE_LEN, 0, 0, 0);
      add_entry("wr fe_select", OP_WRITE, OBS_FE_SEL, `REG_FE_SELECT, 0, 2, 2);
      add_entry("rd fe_select", OP_READ, OBS_RDATA, `REG_FE_SELECT, 0, 0, 2);
      // selected on the access, then the read byte
      add_entry("sel main page", OP_READ, OBS_SEL, `REG_NUM_TRIGGERS, 0, 0, {1'b1, 8'h01});
      add_entry("sel other page", OP_READ, OBS_SEL, {2'b01, `REG_NUM_TRIGGERS}, 0, 0, 0);
      // ctrl bits are reg_arm, arm, arm_pulse, capture_now, fifo_read
      add_entry("flush on", OP_FLUSH, OBS_NONE, 0, 0, 1, 0);
      add_entry("arm write", OP_WRITE, OBS_CTRL, `REG_ARM, 0, 1, 5'b10100);
      add_entry("arm flushing", OP_IDLE, OBS_CTRL, 0, 0, 0, 5'b10000);
      add_entry("flush off", OP_FLUSH, OBS_CTRL, 0, 0, 0, 5'b11000);
      add_entry("rd reg_arm", OP_READ, OBS_RDATA, `REG_ARM, 0, 0, 1);
      add_entry("capture pulse", OP_FE_PULSE, OBS_CTRL, 0, 0, 0, 5'b00000);
      add_entry("rd reg_arm clr", OP_READ, OBS_RDATA, `REG_ARM, 0, 0, 0);
      add_entry("capture now", OP_WRITE, OBS_CTRL, `REG_ARM, 0, 2, 5'b00010);
      add_entry("capture now end", OP_IDLE, OBS_CTRL, 0, 0, 0, 5'b00000);
      add_entry("fifo push", OP_PUSH, OBS_NONE, 0, 0, word, 0);
      add_entry("fifo b0 pop", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 0, 0, 0);
      add_entry("fifo pop count", OP_IDLE, OBS_POPS, 0, 0, 0, 1);
      add_entry("fifo b1", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 1, 0, word[7:0]);
      add_entry("fifo b2", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 2, 0, word[15:8]);
      add_entry("fifo b3", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 3, 0,
                {FIFO_STAT, word[17:16]});
      add_entry("empty b0", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 0, 0, 0);
      add_entry("empty pop count", OP_IDLE, OBS_POPS, 0, 0, 0, 1);
      add_entry("empty b1", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 1, 0, empty_code[7:0]);
      add_entry("empty b2", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 2, 0, empty_code[15:8]);
      add_entry("empty b3", OP_READ, OBS_RDATA, `REG_SNIFF_FIFO_RD, 3, 0,
                {FIFO_STAT, `PW_FIFO_CMD_STRM});
   endtask

   // action edge, then release and check edge, then one idle edge
   task automatic apply_entry(input entry_t e);
      int waited;
      @(posedge cwusb_clk);
      case (e.op)
         OP_WRITE, OP_READ: begin
            reg_address   <= e.addr;
            reg_bytecnt   <= e.bytecnt;
            write_data    <= e.data[7:0];
            reg_addrvalid <= 1'b1;
            reg_write     <= (e.op == OP_WRITE);
            reg_read      <= (e.op == OP_READ);
         end
         OP_PUSH: begin
            fifo_mem[wr_ptr[3:0]] <= e.data;
            wr_ptr                <= wr_ptr + 1'b1;
         end
         OP_FLUSH: flushing <= e.data[0];
         OP_FE_PULSE: begin
            @(posedge fe_clk);
            capture_enable_pulse <= 1'b1;
            @(posedge fe_clk);
            capture_enable_pulse <= 1'b0;
            waited = 0;
            while (reg_arm && waited < 6) begin   // cdc latency varies
               @(negedge cwusb_clk);
               waited++;
            end
            if (reg_arm) begin
               timeouts++;
               $display("Error in %0s: reg_arm not cleared 6 cycles after the fe pulse",
                        e.name);
            end
         end
         default: ;
      endcase
      @(posedge cwusb_clk);
      reg_read      <= 1'b0;
      reg_write     <= 1'b0;
      reg_addrvalid <= 1'b0;
      chk_en        <= (e.obs != OBS_NONE);
      chk_obs       <= e.obs;
      chk_exp       <= e.exp;
      chk_name      <= e.name;
      @(posedge cwusb_clk);
      chk_en <= 1'b0;
   endtask

   initial begin
      fpga_reset           = 1'b1;
      reg_address          = '0;
      reg_bytecnt          = '0;
      write_data           = '0;
      reg_read             = 1'b0;
      reg_write            = 1'b0;
      reg_addrvalid        = 1'b0;
      fifo_status          = FIFO_STAT;
      flushing             = 1'b0;
      capture_enable_pulse = 1'b0;
      wr_ptr               = '0;
      chk_en               = 1'b0;
      chk_obs              = OBS_NONE;
      chk_exp              = '0;
      chk_name             = '0;
      timeouts             = 0;
      build_table();
      repeat (8) @(posedge cwusb_clk);
      fpga_reset <= 1'b0;
      for (int i = 0; i < n_entries; i++)
         apply_entry(tbl[i]);
      @(posedge cwusb_clk);
      $display("errors: %0d value, %0d protocol, %0d timeout",
               value_errors, protocol_errors, timeouts);
      if (value_errors + protocol_errors + timeouts == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // watchdog, 20 cycles per table entry
   initial begin
      wait (n_entries > 0);
      repeat (n_entries * 20) @(posedge cwusb_clk);
      $display("Error: watchdog expired after %0d cycles", n_entries * 20);
      $display("TB FAILED");
      $finish;
   end

endmodule

//--- pw_reg.f
+incdir+rtl
rtl/pw_reg_pkg.sv
rtl/cdc_pulse.sv
rtl/arm_control.sv
rtl/fifo_read_port.sv
rtl/reg_config_bank.sv
rtl/reg_main.sv
dv/reg_main_checker.sv
dv/reg_main_tb.sv

//--- Bender.yml
package:
  name: pw_reg

export_include_dirs:
  - rtl

sources:
  - rtl/pw_reg_pkg.sv
  - rtl/cdc_pulse.sv
  - rtl/arm_control.sv
  - rtl/fifo_read_port.sv
  - rtl/reg_config_bank.sv
  - rtl/reg_main.sv
  - target: test
    files:
      - dv/reg_main_checker.sv
      - dv/reg_main_tb.sv
